// ==== files.f ====
+incdir+src
src/interp_cmd_pkg.sv
src/interp_bus_pkg.sv
src/acc_unit.sv
src/core_ctrl.sv
src/mem_access.sv
src/reply_sender.sv
src/cmd_sequencer.sv
src/debug_interpreter.sv
test/debug_interpreter_tb.sv

// ==== src/acc_unit.sv ====
`default_nettype none
`include "interp_config.svh"

module acc_unit (
    input  wire                         clk,
    input  wire                         reset,
    input  wire interp_cmd_pkg::acc_op_t acc_op,
    input  wire interp_cmd_pkg::arg_t   arg,
    output interp_bus_pkg::acc_t        acc_value
);

    interp_bus_pkg::acc_t arg_sext;

    assign arg_sext = {{(64 - `INTERP_ARG_W){arg[`INTERP_ARG_W-1]}}, arg};

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_value <= '0;
        end else begin
            case (acc_op)
                interp_cmd_pkg::ACC_LOAD_UPPER:
                    acc_value <= {32'h0, arg, acc_value[7:0]}; // Low byte kept
                interp_cmd_pkg::ACC_LOAD_LOWER:
                    acc_value <= {acc_value[63:8], arg[7:0]};
                interp_cmd_pkg::ACC_ADD:
                    acc_value <= acc_value + arg_sext;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/cmd_sequencer.sv ====
`default_nettype none
`include "interp_config.svh"

module cmd_sequencer (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         uart_rx_empty,
    input  wire                         uart_read_response,
    input  wire interp_bus_pkg::word_t  uart_read_data,
    output logic                        uart_read,
    output interp_cmd_pkg::opcode_t     opcode,
    output interp_cmd_pkg::arg_t        arg,
    output interp_bus_pkg::word_t       data_word,
    output interp_cmd_pkg::acc_op_t     acc_op,
    output logic                        mem_write_req,
    output logic                        mem_read_req,
    output logic                        mem_use_acc,
    input  wire                         mem_data_valid,
    output interp_cmd_pkg::core_cmd_t   core_cmd,
    input  wire                         core_done,
    input  wire interp_bus_pkg::word_t  report_word,
    output logic                        send_req,
    output interp_bus_pkg::word_t       send_word,
    input  wire                         send_done,
    input  wire interp_bus_pkg::acc_t   acc_value,
    input  wire interp_bus_pkg::word_t  mem_data
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_DATA_WAIT,
        S_FETCH_DATA,
        S_MEM_WAIT,
        S_CORE_WAIT,
        S_SEND_WAIT
    } state_t;

    state_t                state;
    interp_bus_pkg::word_t cmd_word;
    logic                  report_next; // Run-until report still to go

    assign opcode    = interp_cmd_pkg::opcode_t'(cmd_word[7:0]);
    assign arg       = cmd_word[31:8];
    assign uart_read = (state == S_FETCH) || (state == S_FETCH_DATA);

    always_ff @(posedge clk) begin
        acc_op        <= interp_cmd_pkg::ACC_NONE;
        core_cmd      <= interp_cmd_pkg::CORE_NONE;
        mem_write_req <= 1'b0;
        mem_read_req  <= 1'b0;
        send_req      <= 1'b0;
        if (reset) begin
            state       <= S_IDLE;
            report_next <= 1'b0;
            mem_use_acc <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!uart_rx_empty)
                        state <= S_FETCH;
                end
                S_FETCH: begin
                    if (uart_read_response) begin
                        cmd_word <= uart_read_data;
                        state    <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    state <= S_IDLE; // Default for commands without reply
                    case (opcode)
                        interp_cmd_pkg::OP_PING: begin
                            send_word <= `INTERP_ID;
                            send_req  <= 1'b1;
                            state     <= S_SEND_WAIT;
                        end
                        interp_cmd_pkg::OP_GET_ACC: begin
                            send_word <= acc_value[31:0];
                            send_req  <= 1'b1;
                            state     <= S_SEND_WAIT;
                        end
                        interp_cmd_pkg::OP_LOAD_UPPER: acc_op <= interp_cmd_pkg::ACC_LOAD_UPPER;
                        interp_cmd_pkg::OP_LOAD_LOWER: acc_op <= interp_cmd_pkg::ACC_LOAD_LOWER;
                        interp_cmd_pkg::OP_ADD_ACC:    acc_op <= interp_cmd_pkg::ACC_ADD;
                        interp_cmd_pkg::OP_WRITE_MEM:  state  <= S_DATA_WAIT;
                        interp_cmd_pkg::OP_READ_MEM: begin
                            mem_read_req <= 1'b1;
                            mem_use_acc  <= 1'b0;
                            state        <= S_MEM_WAIT;
                        end
                        interp_cmd_pkg::OP_READ_ACC_POS: begin
                            mem_read_req <= 1'b1;
                            mem_use_acc  <= 1'b1;
                            state        <= S_MEM_WAIT;
                        end
                        interp_cmd_pkg::OP_WRITE_CLK:   core_cmd <= interp_cmd_pkg::CORE_WRITE_CLK;
                        interp_cmd_pkg::OP_STOP_CLK:    core_cmd <= interp_cmd_pkg::CORE_STOP_CLK;
                        interp_cmd_pkg::OP_RESUME_CLK:  core_cmd <= interp_cmd_pkg::CORE_RESUME_CLK;
                        interp_cmd_pkg::OP_SET_TIMEOUT: core_cmd <= interp_cmd_pkg::CORE_SET_TIMEOUT;
                        interp_cmd_pkg::OP_SET_END:     core_cmd <= interp_cmd_pkg::CORE_SET_END;
                        interp_cmd_pkg::OP_RESET_CORE: begin
                            core_cmd <= interp_cmd_pkg::CORE_RESET;
                            state    <= S_CORE_WAIT;
                        end
                        interp_cmd_pkg::OP_UNTIL: begin
                            core_cmd <= interp_cmd_pkg::CORE_UNTIL;
                            state    <= S_CORE_WAIT;
                        end
                        default: state <= S_IDLE; // Unknown opcode dropped
                    endcase
                end
                S_DATA_WAIT: begin
                    if (!uart_rx_empty)
                        state <= S_FETCH_DATA;
                end
                S_FETCH_DATA: begin
                    if (uart_read_response) begin
                        data_word     <= uart_read_data;
                        mem_write_req <= 1'b1;
                        mem_use_acc   <= 1'b0;
                        state         <= S_IDLE;
                    end
                end
                S_MEM_WAIT: begin
                    if (mem_data_valid) begin
                        send_word <= mem_data;
                        send_req  <= 1'b1;
                        state     <= S_SEND_WAIT;
                    end
                end
                S_CORE_WAIT: begin
                    if (core_done) begin
                        if (opcode == interp_cmd_pkg::OP_UNTIL) begin
                            send_word   <= `INTERP_UNTIL_MSG;
                            send_req    <= 1'b1;
                            report_next <= 1'b1;
                            state       <= S_SEND_WAIT;
                        end else begin
                            state <= S_IDLE;
                        end
                    end
                end
                S_SEND_WAIT: begin
                    if (send_done) begin
                        if (report_next) begin
                            send_word   <= report_word;
                            send_req    <= 1'b1;
                            report_next <= 1'b0;
                        end else begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/core_ctrl.sv ====
`default_nettype none
`include "interp_config.svh"

module core_ctrl (
    input  wire                           clk,
    input  wire                           reset,
    input  wire interp_cmd_pkg::core_cmd_t core_cmd,
    input  wire interp_cmd_pkg::arg_t     arg,
    input  wire                           finish_execution,
    output logic                          core_clk_enable,
    output logic                          core_reset,
    output logic                          write_pulse,
    output logic                          reset_bus,
    output logic                          memory_mux_selector,
    output interp_bus_pkg::cycles_t       num_of_cycles_to_pulse,
    output interp_bus_pkg::addr_t         end_position,
    output logic                          core_done,
    output interp_bus_pkg::word_t         report_word
);

    typedef enum logic [1:0] {C_IDLE, C_RESET, C_ENABLE, C_WAIT} state_t;

    state_t                  state;
    logic [7:0]              reset_count;
    interp_bus_pkg::cycles_t timeout;
    interp_bus_pkg::cycles_t wait_count;

    assign report_word = {wait_count[30:0], timeout >= wait_count};

    always_ff @(posedge clk) begin
        write_pulse <= 1'b0;
        core_reset  <= 1'b0;
        reset_bus   <= 1'b0;
        core_done   <= 1'b0;
        if (reset) begin
            state                  <= C_IDLE;
            reset_count            <= '0;
            timeout                <= '0;
            wait_count             <= '0;
            end_position           <= '0;
            num_of_cycles_to_pulse <= '0;
            core_clk_enable        <= 1'b0;
            memory_mux_selector    <= 1'b0;
            reset_bus              <= 1'b1;
        end else begin
            case (state)
                C_IDLE: begin
                    case (core_cmd)
                        interp_cmd_pkg::CORE_WRITE_CLK: begin
                            core_clk_enable        <= 1'b1;
                            num_of_cycles_to_pulse <= interp_bus_pkg::cycles_t'(arg);
                            write_pulse            <= 1'b1;
                        end
                        interp_cmd_pkg::CORE_STOP_CLK:    core_clk_enable <= 1'b0;
                        interp_cmd_pkg::CORE_RESUME_CLK:  core_clk_enable <= 1'b1;
                        interp_cmd_pkg::CORE_SET_TIMEOUT: timeout <= interp_bus_pkg::cycles_t'(arg);
                        interp_cmd_pkg::CORE_SET_END:
                            end_position <= interp_bus_pkg::addr_t'({arg, 2'b00});
                        interp_cmd_pkg::CORE_RESET, interp_cmd_pkg::CORE_UNTIL: begin
                            if (core_cmd == interp_cmd_pkg::CORE_UNTIL) begin
                                memory_mux_selector <= 1'b1; // Core owns memory
                                reset_bus           <= 1'b1;
                                wait_count          <= '0;
                            end
                            core_reset             <= 1'b1;
                            core_clk_enable        <= 1'b1;
                            num_of_cycles_to_pulse <= interp_bus_pkg::cycles_t'(`INTERP_RESET_CYCLES);
                            write_pulse            <= 1'b1;
                            reset_count            <= '0;
                            state                  <= C_RESET;
                        end
                        default: ;
                    endcase
                end
                C_RESET: begin
                    core_reset  <= 1'b1;
                    reset_count <= reset_count + 8'd1;
                    if (reset_count == `INTERP_RESET_CYCLES) begin
                        core_clk_enable <= 1'b0;
                        if (memory_mux_selector) begin
                            state <= C_ENABLE;
                        end else begin
                            core_done <= 1'b1;
                            state     <= C_IDLE;
                        end
                    end
                end
                C_ENABLE: begin
                    core_clk_enable        <= 1'b1;
                    num_of_cycles_to_pulse <= timeout;
                    write_pulse            <= 1'b1;
                    state                  <= C_WAIT;
                end
                C_WAIT: begin
                    if (finish_execution || wait_count == timeout) begin
                        core_clk_enable     <= 1'b0;
                        memory_mux_selector <= 1'b0;
                        reset_bus           <= 1'b1;
                        core_done           <= 1'b1;
                        state               <= C_IDLE;
                    end else begin
                        wait_count <= wait_count + 32'd1;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // Reset without clock only in the closing cycle of the sequence
    assert property (@(posedge clk) disable iff (reset)
        core_reset && !core_clk_enable |=> !core_reset);

    assert property (@(posedge clk) disable iff (reset)
        memory_mux_selector |-> state != C_IDLE);

endmodule

`default_nettype wire

// ==== src/debug_interpreter.sv ====
`default_nettype none

module debug_interpreter (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          uart_rx_empty,
    input  wire                          uart_read_response,
    input  wire interp_bus_pkg::word_t   uart_read_data,
    output logic                         uart_read,
    input  wire                          uart_write_response,
    output logic                         uart_write,
    output interp_bus_pkg::word_t        uart_write_data,
    input  wire                          finish_execution,
    output logic                         core_clk_enable,
    output logic                         core_reset,
    output logic                         write_pulse,
    output interp_bus_pkg::cycles_t      num_of_cycles_to_pulse,
    output logic                         reset_bus,
    output logic                         memory_mux_selector,
    output interp_bus_pkg::addr_t        end_position,
    output logic                         memory_read,
    output logic                         memory_write,
    output interp_bus_pkg::addr_t        address,
    output interp_bus_pkg::word_t        write_data,
    input  wire interp_bus_pkg::word_t   read_data
);

    interp_cmd_pkg::arg_t      arg;
    interp_bus_pkg::word_t     data_word;
    interp_cmd_pkg::acc_op_t   acc_op;
    interp_bus_pkg::acc_t      acc_value;
    logic                      mem_write_req;
    logic                      mem_read_req;
    logic                      mem_use_acc;
    logic                      mem_data_valid;
    interp_bus_pkg::word_t     mem_data;
    interp_cmd_pkg::core_cmd_t core_cmd;
    logic                      core_done;
    interp_bus_pkg::word_t     report_word;
    logic                      send_req;
    interp_bus_pkg::word_t     send_word;
    logic                      send_done;

    cmd_sequencer seq_i (
        .clk(clk), .reset(reset),
        .uart_rx_empty(uart_rx_empty),
        .uart_read_response(uart_read_response),
        .uart_read_data(uart_read_data),
        .uart_read(uart_read),
        .opcode(),
        .arg(arg),
        .data_word(data_word),
        .acc_op(acc_op),
        .mem_write_req(mem_write_req),
        .mem_read_req(mem_read_req),
        .mem_use_acc(mem_use_acc),
        .mem_data_valid(mem_data_valid),
        .core_cmd(core_cmd),
        .core_done(core_done),
        .report_word(report_word),
        .send_req(send_req),
        .send_word(send_word),
        .send_done(send_done),
        .acc_value(acc_value),
        .mem_data(mem_data)
    );

    acc_unit acc_i (
        .clk(clk), .reset(reset),
        .acc_op(acc_op),
        .arg(arg),
        .acc_value(acc_value)
    );

    core_ctrl core_i (
        .clk(clk), .reset(reset),
        .core_cmd(core_cmd),
        .arg(arg),
        .finish_execution(finish_execution),
        .core_clk_enable(core_clk_enable),
        .core_reset(core_reset),
        .write_pulse(write_pulse),
        .reset_bus(reset_bus),
        .memory_mux_selector(memory_mux_selector),
        .num_of_cycles_to_pulse(num_of_cycles_to_pulse),
        .end_position(end_position),
        .core_done(core_done),
        .report_word(report_word)
    );

    mem_access mem_i (
        .clk(clk), .reset(reset),
        .mem_write_req(mem_write_req),
        .mem_read_req(mem_read_req),
        .mem_use_acc(mem_use_acc),
        .arg(arg),
        .data_word(data_word),
        .acc_value(acc_value),
        .read_data(read_data),
        .memory_read(memory_read),
        .memory_write(memory_write),
        .address(address),
        .write_data(write_data),
        .mem_data(mem_data),
        .mem_data_valid(mem_data_valid)
    );

    reply_sender reply_i (
        .clk(clk), .reset(reset),
        .send_req(send_req),
        .send_word(send_word),
        .uart_write_response(uart_write_response),
        .uart_write(uart_write),
        .uart_write_data(uart_write_data),
        .send_done(send_done)
    );

endmodule

`default_nettype wire

// ==== src/interp_bus_pkg.sv ====
`default_nettype none

package interp_bus_pkg;

    // UART and memory data word
    typedef logic [31:0] word_t;

    // Byte address on the memory bus
    typedef logic [31:0] addr_t;

    typedef logic [63:0] acc_t;

    // Timeout, pulse count and wait counter
    typedef logic [31:0] cycles_t;

endpackage

`default_nettype wire

// ==== src/interp_cmd_pkg.sv ====
`default_nettype none
`include "interp_config.svh"

package interp_cmd_pkg;

    typedef enum logic [`INTERP_OP_W-1:0] {
        OP_ADD_ACC      = 8'h41, // A
        OP_SET_END      = 8'h44, // D
        OP_WRITE_CLK    = 8'h43, // C
        OP_READ_ACC_POS = 8'h47, // G
        OP_READ_MEM     = 8'h4C, // L
        OP_RESET_CORE   = 8'h52, // R
        OP_STOP_CLK     = 8'h53, // S
        OP_SET_TIMEOUT  = 8'h54, // T
        OP_LOAD_UPPER   = 8'h55, // U
        OP_WRITE_MEM    = 8'h57, // W
        OP_GET_ACC      = 8'h61, // a
        OP_LOAD_LOWER   = 8'h6C, // l
        OP_PING         = 8'h70, // p
        OP_RESUME_CLK   = 8'h72, // r
        OP_UNTIL        = 8'h75  // u
    } opcode_t;

    typedef logic [`INTERP_ARG_W-1:0] arg_t;

    typedef enum logic [1:0] {
        ACC_NONE,
        ACC_LOAD_UPPER,
        ACC_LOAD_LOWER,
        ACC_ADD
    } acc_op_t;

    typedef enum logic [2:0] {
        CORE_NONE,
        CORE_WRITE_CLK,
        CORE_STOP_CLK,
        CORE_RESUME_CLK,
        CORE_RESET,
        CORE_SET_TIMEOUT,
        CORE_SET_END,
        CORE_UNTIL
    } core_cmd_t;

endpackage

`default_nettype wire

// ==== src/interp_config.svh ====
`ifndef INTERP_CONFIG_SVH
`define INTERP_CONFIG_SVH

`define INTERP_ID           32'h7700006A
`define INTERP_RESET_CYCLES 8'd20
`define INTERP_UNTIL_MSG    32'h6C75636B // ASCII "luck"

// Command word split
`define INTERP_OP_W         8
`define INTERP_ARG_W        24

`endif

// ==== src/mem_access.sv ====
`default_nettype none

module mem_access (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        mem_write_req,
    input  wire                        mem_read_req,
    input  wire                        mem_use_acc,
    input  wire interp_cmd_pkg::arg_t  arg,
    input  wire interp_bus_pkg::word_t data_word,
    input  wire interp_bus_pkg::acc_t  acc_value,
    input  wire interp_bus_pkg::word_t read_data,
    output logic                       memory_read,
    output logic                       memory_write,
    output interp_bus_pkg::addr_t      address,
    output interp_bus_pkg::word_t      write_data,
    output interp_bus_pkg::word_t      mem_data,
    output logic                       mem_data_valid
);

    interp_bus_pkg::addr_t base;
    logic                  read_dly; // Memory drives read_data now

    assign base = mem_use_acc ? acc_value[31:0] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            memory_read    <= 1'b0;
            memory_write   <= 1'b0;
            read_dly       <= 1'b0;
            mem_data_valid <= 1'b0;
        end else begin
            memory_read    <= mem_read_req;
            memory_write   <= mem_write_req;
            read_dly       <= memory_read;
            mem_data_valid <= read_dly;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_read_req || mem_write_req)
            address <= base + interp_bus_pkg::addr_t'({arg, 2'b00}); // Word index to bytes
        if (mem_write_req)
            write_data <= data_word;
        if (read_dly)
            mem_data <= read_data;
    end

    assert property (@(posedge clk) disable iff (reset) !(memory_read && memory_write));

endmodule

`default_nettype wire

// ==== src/reply_sender.sv ====
`default_nettype none

module reply_sender (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        send_req,
    input  wire interp_bus_pkg::word_t send_word,
    input  wire                        uart_write_response,
    output logic                       uart_write,
    output interp_bus_pkg::word_t      uart_write_data,
    output logic                       send_done
);

    logic pending; // Waiting on the UART

    always_ff @(posedge clk) begin
        uart_write <= 1'b0;
        send_done  <= 1'b0;
        if (reset) begin
            pending <= 1'b0;
        end else if (send_req && !pending) begin
            uart_write_data <= send_word;
            uart_write      <= 1'b1;
            pending         <= 1'b1;
        end else if (pending && uart_write_response) begin
            pending   <= 1'b0;
            send_done <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset) send_req |-> !pending);

endmodule

`default_nettype wire

// ==== test/debug_interpreter_tb.sv ====
`default_nettype none
`include "interp_config.svh"

module debug_interpreter_tb;

    localparam int REPLY_TIMEOUT = 2000; // Cycles allowed per reply

    logic                    clk;
    logic                    reset = 1'b1;
    logic                    uart_rx_empty = 1'b1;
    logic                    uart_read_response = 1'b0;
    interp_bus_pkg::word_t   uart_read_data = '0;
    logic                    uart_read;
    logic                    uart_write_response = 1'b0;
    logic                    uart_write;
    interp_bus_pkg::word_t   uart_write_data;
    logic                    finish_execution = 1'b0;
    logic                    core_clk_enable;
    logic                    core_reset;
    logic                    write_pulse;
    interp_bus_pkg::cycles_t num_of_cycles_to_pulse;
    logic                    reset_bus;
    logic                    memory_mux_selector;
    interp_bus_pkg::addr_t   end_position;
    logic                    memory_read;
    logic                    memory_write;
    interp_bus_pkg::addr_t   address;
    interp_bus_pkg::word_t   write_data;
    interp_bus_pkg::word_t   read_data = '0;

    logic [31:0] rx_q[$];  // Words waiting in the UART receive FIFO
    logic [31:0] got_q[$]; // Words written by the DUT
    logic [31:0] mem [0:255];
    logic [31:0] last_pulse = '0;
    logic        mux_seen = 1'b0;
    logic        bus_seen = 1'b0;
    logic        bus_prev = 1'b0;
    integer      seed = 53704;
    int          wr_delay = 0;
    int          finish_delay = 0; // Zero means the core never finishes
    int          run_cycles = 0;
    int          reset_len = 0;
    int          reset_runs = 0;
    int          pulse_count = 0;

    debug_interpreter dut_i (
        .clk(clk), .reset(reset),
        .uart_rx_empty(uart_rx_empty),
        .uart_read_response(uart_read_response),
        .uart_read_data(uart_read_data),
        .uart_read(uart_read),
        .uart_write_response(uart_write_response),
        .uart_write(uart_write),
        .uart_write_data(uart_write_data),
        .finish_execution(finish_execution),
        .core_clk_enable(core_clk_enable),
        .core_reset(core_reset),
        .write_pulse(write_pulse),
        .num_of_cycles_to_pulse(num_of_cycles_to_pulse),
        .reset_bus(reset_bus),
        .memory_mux_selector(memory_mux_selector),
        .end_position(end_position),
        .memory_read(memory_read),
        .memory_write(memory_write),
        .address(address),
        .write_data(write_data),
        .read_data(read_data)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            stop_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h",
                               name, actual, expected));
    endtask

    task automatic wait_reply(output logic [31:0] word);
        int waited;
        waited = 0;
        while (got_q.size() == 0) begin
            @(posedge clk);
            waited++;
            if (waited > REPLY_TIMEOUT)
                stop_run("Timed out waiting for a reply on the UART");
        end
        word = got_q.pop_front();
    endtask

    // Ping as a barrier since its reply follows all earlier commands
    task automatic sync_idle();
        logic [31:0] word;
        rx_q.push_back(32'(interp_cmd_pkg::OP_PING));
        wait_reply(word);
        check_value("ping reply at sync", word, `INTERP_ID);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        for (int i = 0; i < 256; i++)
            mem[i] = 32'hC0DE0000 | (i << 2); // Byte address in the low bits
    end

    // UART receive side with one response per read
    always @(posedge clk) begin
        if (uart_read && !uart_read_response && rx_q.size() > 0) begin
            uart_read_data     <= rx_q.pop_front();
            uart_read_response <= 1'b1;
        end else begin
            uart_read_response <= 1'b0;
        end
        uart_rx_empty <= (rx_q.size() == 0);
    end

    // UART transmit side with random response delay
    always @(posedge clk) begin
        uart_write_response <= 1'b0;
        if (uart_write) begin
            check_value("memory_mux_selector at uart_write", memory_mux_selector, 0);
            got_q.push_back(uart_write_data);
            wr_delay = ($random(seed) & 7) + 1;
        end else if (wr_delay > 0) begin
            wr_delay = wr_delay - 1;
            if (wr_delay == 0)
                uart_write_response <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (memory_write)
            mem[address[9:2]] <= write_data;
        if (memory_read)
            read_data <= mem[address[9:2]];
    end

    // Core model finishing a set number of cycles after it gets memory
    always @(posedge clk) begin
        if (!memory_mux_selector) begin
            run_cycles       <= 0;
            finish_execution <= 1'b0;
        end else begin
            run_cycles <= run_cycles + 1;
            if (finish_delay != 0 && run_cycles == finish_delay)
                finish_execution <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (core_reset) begin
                if (reset_len <= `INTERP_RESET_CYCLES)
                    check_value("core_clk_enable during core_reset", core_clk_enable, 1);
                reset_len = reset_len + 1;
            end else if (reset_len != 0) begin
                check_value("core_reset high cycles", reset_len, `INTERP_RESET_CYCLES + 2);
                reset_runs = reset_runs + 1;
                reset_len  = 0;
            end
            if (write_pulse) begin
                pulse_count = pulse_count + 1;
                last_pulse  = num_of_cycles_to_pulse;
            end
            if (memory_mux_selector)
                mux_seen = 1'b1;
            if (reset_bus && memory_mux_selector)
                bus_seen = 1'b1;
            if (bus_prev)
                check_value("reset_bus after its pulse", reset_bus, 0);
        end
        bus_prev = reset_bus && !reset;
    end

    initial begin
        int          fd;
        string       line;
        logic [7:0]  kind;
        logic [31:0] value;
        logic [31:0] reply;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        fd = $fopen("test/interp_patterns.txt", "r");
        if (fd == 0)
            stop_run("Could not open the pattern file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 3 || line[0] == "#")
                continue;
            if ($sscanf(line, "%c %h", kind, value) != 2)
                stop_run($sformatf("Malformed line in the pattern file: %s", line));
            case (kind)
                "S": rx_q.push_back(value);
                "E": begin
                    wait_reply(reply);
                    check_value("uart_write_data", reply, value);
                end
                "B": begin
                    wait_reply(reply);
                    check_value("report bit 0", reply[0], 1);
                    check_value("report count within timeout", (reply >> 1) <= value, 1);
                    check_value("report count before finish", (reply >> 1) < finish_delay, 1);
                end
                "Q": sync_idle();
                "K": check_value("core_clk_enable", core_clk_enable, value);
                "P": begin
                    check_value("num_of_cycles_to_pulse at write_pulse", last_pulse, value);
                    check_value("write_pulse count", pulse_count, 1);
                    pulse_count = 0;
                end
                "H": check_value("core reset sequences", reset_runs, value);
                "N": check_value("end_position", end_position, value);
                "M": begin
                    check_value("memory_mux_selector", memory_mux_selector, value);
                    check_value("memory_mux_selector raised in run", mux_seen, 1);
                    check_value("reset_bus pulsed in run", bus_seen, 1);
                    mux_seen = 1'b0;
                    bus_seen = 1'b0;
                end
                "F": finish_delay = value;
                default: stop_run($sformatf("Unknown line kind in the pattern file: %s", line));
            endcase
        end
        $fclose(fd);
        if (got_q.size() == 0 && rx_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_run("Replies or commands were left over at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== test/interp_patterns.txt ====
# Columns: kind letter, hex word. S send command, E expect reply, B report bound,
# Q sync by ping, K clock enable, P pulse count, H reset runs, N end, M mux, F finish
S 00000070
E 7700006A
S 12345655
S 0000786C
S FFFFF041
S 00000061
E 12345668
S 00000557
S DEADBEEF
S 0000054C
E DEADBEEF
S 00000055
S 0000086C
S 00000347
E DEADBEEF
S 00001047
E C0DE0048
S 00000052
Q 00000000
H 00000001
P 00000014
K 00000000
S 00006443
Q 00000000
P 00000064
K 00000001
S 00000053
Q 00000000
K 00000000
S 00000072
Q 00000000
K 00000001
S 00003254
S 00010044
F 00000000
S 00000075
E 6C75636B
E 00000065
Q 00000000
N 00000400
M 00000000
K 00000000
H 00000002
S 0003E854
F 00000028
S 00000075
E 6C75636B
B 000003E8
Q 00000000
M 00000000
H 00000003
